// File: fp_div_pkg.sv
`default_nettype none

package fp_div_pkg;

    ////////////////////////////////////////////////////////////
    // binary32 field widths
    ////////////////////////////////////////////////////////////

    // stored exponent field
    localparam int EXP_W  = 8;
    // stored fraction, hidden bit not included
    localparam int FRAC_W = 23;
    // mantissa with the hidden bit restored
    localparam int MANT_W = FRAC_W + 1;
    // quotient bits: one integer bit plus 24 fraction bits
    localparam int QUOT_W = MANT_W + 1;
    // signed working exponent, wide enough that
    // overflow and underflow never wrap
    localparam int SEXP_W = 10;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////

    // signed working exponent
    typedef logic signed [SEXP_W-1:0] sexp_t;

    // packed binary32 word, sign on top
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [FRAC_W-1:0] fraction;
    } fp_word_t;

    // result forced by the operands
    // NORMAL means the computed value is used
    typedef enum logic [1:0] {
        CLS_NORMAL = 2'd0,
        CLS_ZERO   = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } op_class_t;

    // sideband carried beside the mantissa divide, 13 bits
    typedef struct packed {
        logic      sign;
        sexp_t     exp;
        op_class_t cls;
    } div_side_t;

    // work word handed from stage to stage, 87 bits
    typedef struct packed {
        logic [MANT_W:0]   rem;
        logic [MANT_W-1:0] divisor;
        logic [QUOT_W-1:0] quot;
        div_side_t         side;
    } div_state_t;

    ////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////

    // added back after the exponent subtraction
    localparam sexp_t EXP_BIAS = 127;

    // all-ones exponent field, infinity and NaN encoding
    localparam logic [EXP_W-1:0] EXP_MAX = 8'hFF;

    // canonical quiet NaN
    localparam fp_word_t QNAN_WORD = 32'h7FC0_0000;

endpackage

`default_nettype wire

// File: fp_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    in_valid,
    input  wire fp_div_pkg::fp_word_t    in_a,
    input  wire fp_div_pkg::fp_word_t    in_b,
    output logic                         out_valid,
    output fp_div_pkg::div_state_t       out_state
);

    ////////////////////////////////////////////////////////////
    // operand classification
    ////////////////////////////////////////////////////////////

    // exponent field of zero counts as zero
    // subnormals are not supported
    logic a_zero;
    logic b_zero;

    assign a_zero = (in_a.exponent == '0);
    assign b_zero = (in_b.exponent == '0);

    fp_div_pkg::op_class_t cls;

    always_comb begin
        // 0/0 has priority over x/0
        if (a_zero && b_zero) begin
            cls = fp_div_pkg::CLS_NAN;
        end else if (b_zero) begin
            cls = fp_div_pkg::CLS_INF;
        end else if (a_zero) begin
            cls = fp_div_pkg::CLS_ZERO;
        end else begin
            cls = fp_div_pkg::CLS_NORMAL;
        end
    end

    ////////////////////////////////////////////////////////////
    // first work word
    ////////////////////////////////////////////////////////////

    fp_div_pkg::div_state_t next_state;

    always_comb begin
        // result sign
        next_state.side.sign = in_a.sign ^ in_b.sign;
        // ea - eb + bias, signed so it can run out of range
        next_state.side.exp  = fp_div_pkg::sexp_t'(in_a.exponent)
                             - fp_div_pkg::sexp_t'(in_b.exponent)
                             + fp_div_pkg::EXP_BIAS;
        next_state.side.cls  = cls;
        // remainder is one bit wider than the mantissa
        next_state.rem       = {2'b01, in_a.fraction};
        // hidden bit back in front of the divisor fraction
        next_state.divisor   = {1'b1, in_b.fraction};
        // quotient bits shift in from the bottom
        next_state.quot      = '0;
    end

    // valid strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // work word, loads only with a new operand pair
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_state <= next_state;
        end
    end

endmodule

`default_nettype wire

// File: mant_div_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mant_div_stage #(
    // quotient bits produced in this cycle
    parameter int BITS_PER_STAGE = 5
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      in_valid,
    input  wire fp_div_pkg::div_state_t    in_state,
    output logic                           out_valid,
    output fp_div_pkg::div_state_t         out_state
);

    ////////////////////////////////////////////////////////////
    // unrolled restoring steps
    ////////////////////////////////////////////////////////////

    // divisor zero-extended to the remainder width
    logic [fp_div_pkg::MANT_W:0] divisor_ext;

    assign divisor_ext = {1'b0, in_state.divisor};

    // working copy walked through the steps
    fp_div_pkg::div_state_t step_state;
    // one quotient bit per step
    logic [BITS_PER_STAGE-1:0] q_bits;

    always_comb begin
        step_state = in_state;
        q_bits     = '0;
        for (int i = 0; i < BITS_PER_STAGE; i++) begin
            // divisor fits: quotient bit is 1, subtract
            q_bits[i] = (step_state.rem >= divisor_ext);
            if (q_bits[i]) begin
                step_state.rem = step_state.rem - divisor_ext;
            end
            // remainder < divisor here, so doubling
            // it still fits in MANT_W+1 bits
            step_state.rem  = {step_state.rem[fp_div_pkg::MANT_W-1:0], 1'b0};
            // new bit enters at the lsb
            step_state.quot = {step_state.quot[fp_div_pkg::QUOT_W-2:0], q_bits[i]};
        end
        // sideband and divisor ride along untouched
        step_state.divisor = in_state.divisor;
        step_state.side    = in_state.side;
    end

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    // valid strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // work word, only moves with valid data
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_state <= step_state;
        end
    end

endmodule

`default_nettype wire

// File: fp_normalize_pack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_normalize_pack (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      in_valid,
    input  wire fp_div_pkg::div_state_t    in_state,
    output logic                           out_valid,
    output fp_div_pkg::fp_word_t           out_result
);

    ////////////////////////////////////////////////////////////
    // one-bit normalization
    ////////////////////////////////////////////////////////////

    // quotient lies in [0.5, 2), so at most one shift
    logic [fp_div_pkg::FRAC_W-1:0] frac_n;
    fp_div_pkg::sexp_t             exp_n;

    always_comb begin
        if (in_state.quot[fp_div_pkg::QUOT_W-1]) begin
            // quotient >= 1, drop the integer bit and the lsb
            frac_n = in_state.quot[fp_div_pkg::QUOT_W-2 -: fp_div_pkg::FRAC_W];
            exp_n  = in_state.side.exp;
        end else begin
            // quotient below 1, bit 23 becomes hidden
            frac_n = in_state.quot[fp_div_pkg::FRAC_W-1:0];
            exp_n  = in_state.side.exp - fp_div_pkg::sexp_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // range check and special cases
    ////////////////////////////////////////////////////////////

    // canned results with the result sign
    fp_div_pkg::fp_word_t inf_word;
    fp_div_pkg::fp_word_t zero_word;
    fp_div_pkg::fp_word_t result_d;

    assign inf_word  = {in_state.side.sign, fp_div_pkg::EXP_MAX, {fp_div_pkg::FRAC_W{1'b0}}};
    assign zero_word = {in_state.side.sign, {fp_div_pkg::EXP_W{1'b0}},
                        {fp_div_pkg::FRAC_W{1'b0}}};

    always_comb begin
        case (in_state.side.cls)
            fp_div_pkg::CLS_NAN: begin
                result_d = fp_div_pkg::QNAN_WORD;
            end
            fp_div_pkg::CLS_INF: begin
                result_d = inf_word;
            end
            fp_div_pkg::CLS_ZERO: begin
                result_d = zero_word;
            end
            default: begin
                // overflow saturates, underflow flushes
                if (exp_n >= fp_div_pkg::sexp_t'(fp_div_pkg::EXP_MAX)) begin
                    result_d = inf_word;
                end else if (exp_n <= fp_div_pkg::sexp_t'(0)) begin
                    result_d = zero_word;
                end else begin
                    // in range, low bits are the field
                    result_d.sign     = in_state.side.sign;
                    result_d.exponent = exp_n[fp_div_pkg::EXP_W-1:0];
                    result_d.fraction = frac_n;
                end
            end
        endcase
    end

    // valid strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // result word, held between results
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_result <= result_d;
        end
    end

endmodule

`default_nettype wire

// File: fp_div_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_div_top #(
    // must divide QUOT_W evenly, e.g. 1, 5 or 25
    parameter int BITS_PER_STAGE = 5
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    in_valid,
    input  wire fp_div_pkg::fp_word_t    in_a,
    input  wire fp_div_pkg::fp_word_t    in_b,
    output logic                         out_valid,
    output fp_div_pkg::fp_word_t         out_result
);

    ////////////////////////////////////////////////////////////
    // pipeline: unpack, NUM_STAGES divide stages, pack
    ////////////////////////////////////////////////////////////

    // latency is NUM_STAGES + 2 cycles, 7 with 5 bits per stage
    localparam int NUM_STAGES = fp_div_pkg::QUOT_W / BITS_PER_STAGE;

    // index 0 is the unpack output,
    // index NUM_STAGES the last divide stage
    logic                   stg_valid [0:NUM_STAGES];
    fp_div_pkg::div_state_t stg_state [0:NUM_STAGES];

    // operand split, classify, sign and exponent
    fp_unpack fp_unpack_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_a      (in_a),
        .in_b      (in_b),
        .out_valid (stg_valid[0]),
        .out_state (stg_state[0])
    );

    // mantissa divide, BITS_PER_STAGE quotient bits per cycle
    genvar g;
    generate
        for (g = 0; g < NUM_STAGES; g++) begin : gen_div_stage
            mant_div_stage #(
                .BITS_PER_STAGE (BITS_PER_STAGE)
            ) mant_div_stage_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (stg_valid[g]),
                .in_state  (stg_state[g]),
                .out_valid (stg_valid[g+1]),
                .out_state (stg_state[g+1])
            );
        end
    endgenerate

    // normalize, range and special cases, pack
    fp_normalize_pack fp_normalize_pack_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (stg_valid[NUM_STAGES]),
        .in_state   (stg_state[NUM_STAGES]),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

// File: tb_fp_div.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_div;

    ////////////////////////////////////////////////////////////
    // parameters and DUT signals
    ////////////////////////////////////////////////////////////

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int BITS_PER_STAGE = 5;
    // unpack + divide stages + pack
    localparam int NUM_STAGES     = fp_div_pkg::QUOT_W / BITS_PER_STAGE;
    localparam int LATENCY        = NUM_STAGES + 2;
    localparam int DRAIN_LIMIT    = 50;
    // out_valid rises LATENCY edges after the edge that drives in_valid
    // and the monitor looks half a period after that
    localparam logic [63:0] RESULT_DELAY =
        64'(LATENCY * CLK_PERIOD + CLK_PERIOD / 2);

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 in_valid;
    fp_div_pkg::fp_word_t in_a;
    fp_div_pkg::fp_word_t in_b;
    logic                 out_valid;
    fp_div_pkg::fp_word_t out_result;

    // one operand pair in flight
    typedef struct packed {
        fp_div_pkg::fp_word_t a;
        fp_div_pkg::fp_word_t b;
        fp_div_pkg::fp_word_t expected;
        logic [63:0]          t_drive;
    } pending_t;

    pending_t pending[$];

    int value_errors  = 0;
    int timing_errors = 0;
    int other_errors  = 0;
    int checked       = 0;
    int vectors       = 0;

    fp_div_top #(
        .BITS_PER_STAGE (BITS_PER_STAGE)
    ) fp_div_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    // free-running clock
    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // driver tasks
    ////////////////////////////////////////////////////////////

    // n cycles with in_valid low
    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // one pair on the next edge with its expected word and drive time queued
    task automatic drive_pair(input fp_div_pkg::fp_word_t a,
                              input fp_div_pkg::fp_word_t b,
                              input fp_div_pkg::fp_word_t expected);
        pending_t entry;
        @(posedge clk);
        in_valid <= 1'b1;
        in_a     <= a;
        in_b     <= b;
        entry.a        = a;
        entry.b        = b;
        entry.expected = expected;
        entry.t_drive  = $time;
        pending.push_back(entry);
    endtask

    ////////////////////////////////////////////////////////////
    // monitor and scoreboard
    ////////////////////////////////////////////////////////////

    // pop the oldest pair and compare value and arrival time
    task automatic check_result();
        pending_t    entry;
        logic [63:0] expected_time;
        if (pending.size() == 0) begin
            $display("out_valid went high at %0t with no operand pair in flight", $time);
            other_errors++;
        end else begin
            entry         = pending.pop_front();
            expected_time = entry.t_drive + RESULT_DELAY;
            if (out_result !== entry.expected) begin
                $display("** Error at %0t: %h / %h expected %h got %h",
                         $time, entry.a, entry.b, entry.expected, out_result);
                value_errors++;
            end
            if ($time != expected_time) begin
                $display("** Error at %0t: result of %h / %h due at %0t",
                         $time, entry.a, entry.b, expected_time);
                timing_errors++;
            end
            checked++;
        end
    endtask

    // outputs sampled on the falling edge away from the register updates
    always @(negedge clk) begin
        if (!rst_n) begin
            if (out_valid !== 1'b0) begin
                $display("out_valid was not low during reset at %0t", $time);
                other_errors++;
            end
        end else if (out_valid === 1'b1) begin
            check_result();
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus from the vector file
    ////////////////////////////////////////////////////////////

    initial begin
        int                   fd;
        int                   fields;
        int                   gap;
        int                   drain_cycles;
        string                line;
        fp_div_pkg::fp_word_t a;
        fp_div_pkg::fp_word_t b;
        fp_div_pkg::fp_word_t expected;

        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_a     = '0;
        in_b     = '0;

        // synchronous reset held for a few edges
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;

        fd = $fopen("fp_div_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open fp_div_stimulus.txt");
            other_errors++;
        end else begin
            // comment and blank lines give fewer than four fields
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%h %h %h %d", a, b, expected, gap);
                if (fields == 4) begin
                    idle_cycles(gap);
                    drive_pair(a, b, expected);
                    vectors++;
                end
            end
            $fclose(fd);
        end
        idle_cycles(1);

        // wait for the pipeline to empty
        drain_cycles = 0;
        while (pending.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            drain_cycles++;
        end
        if (pending.size() != 0) begin
            $display("timeout: %0d results still missing after %0d cycles",
                     pending.size(), DRAIN_LIMIT);
            other_errors++;
        end

        // a few more cycles to catch stray out_valid strobes
        idle_cycles(LATENCY + 2);

        if (vectors == 0) begin
            $display("no vectors were read from the stimulus file");
            other_errors++;
        end

        $display("Summary: %0d checked, %0d value errors, %0d latency errors, %0d other errors",
                 checked, value_errors, timing_errors, other_errors);
        if (value_errors == 0 && timing_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fp_div_stimulus.txt
// dividend divisor expected idle_cycles_before_pair
// words in hex, idle count in decimal, quotients truncated
// normal quotients, integer bit set
3F800000 3F800000 3F800000 4
40C00000 40000000 40400000 0
3F800000 40000000 3F000000 0
41000000 3F000000 41800000 2
41200000 40800000 40200000 0
40E00000 40400000 40155555 0
3FC00000 3FA00000 3F999999 1
C0C00000 C0000000 40400000 0
7F7FFFFF 3F800000 7F7FFFFF 1
// quotient mantissa below one, exponent decremented
3F800000 40400000 3EAAAAAA 0
40000000 40400000 3F2AAAAA 0
BF800000 40400000 BEAAAAAA 3
3F800000 C0400000 BEAAAAAA 0
3F800000 41200000 3DCCCCCC 0
// zero dividend, sign is the xor of the operand signs
00000000 40000000 00000000 2
80000000 40000000 80000000 0
00000000 C0400000 80000000 0
80000000 C0000000 00000000 0
00000001 3F800000 00000000 1
// zero divisor gives infinity, zero over zero gives nan
3F800000 00000000 7F800000 0
BF800000 00000000 FF800000 0
3F800000 80000000 FF800000 5
40000000 007FFFFF 7F800000 0
00000000 00000000 7FC00000 0
80000000 80000000 7FC00000 0
00000000 00000001 7FC00000 0
// exponent overflow saturates
7F000000 3F000000 7F800000 0
FF000000 3E800000 FF800000 0
7F000000 3F400000 7F2AAAAA 0
7F7FFFFF 00800000 7F800000 0
7F7FFFFF 80800000 FF800000 0
// exponent underflow flushes
00800000 40000000 00000000 2
80800000 40000000 80000000 0
01000000 40000000 00800000 0
00800000 3FC00000 00000000 0
00800000 FF000000 80000000 0
// burst with no idle cycles
40400000 3F800000 40400000 6
3F800000 40400000 3EAAAAAA 0
C1200000 40800000 C0200000 0
00000000 BF800000 80000000 0
BF800000 80000000 7F800000 0
7F000000 3F000000 7F800000 0
00800000 40000000 00000000 0
40E00000 40400000 40155555 0

// File: filelist.f
fp_div_pkg.sv
fp_unpack.sv
mant_div_stage.sv
fp_normalize_pack.sv
fp_div_top.sv
tb_fp_div.sv

// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing -j 0
TOP       = tb_fp_div
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Done: no errors
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail is taken from the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
